/* Bender.yml */
package:
  name: wb_sram

sources:
  - include_dirs:
      - .
    files:
      - sram_pkg.sv
      - sram_req_if.sv
      - spram_16k16.sv
      - sram_bank_array.sv
      - wb_sram_front.sv
      - wb_sram_top.sv
      - target: test
        files:
          - tb_wb_sram_chk.sv
          - tb_wb_sram.sv

/* sim.f */
+incdir+.
sram_pkg.sv
sram_req_if.sv
spram_16k16.sv
sram_bank_array.sv
wb_sram_front.sv
wb_sram_top.sv
tb_wb_sram_chk.sv
tb_wb_sram.sv

/* spram_16k16.sv */
// ##############################
// Behavioral 16K x 16 single-port RAM macro
// Nibble write mask, registered read port
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module spram_16k16 (
    input  logic                     clk,
    input  logic [`SRAM_ROW_AW-1:0]  ad,
    input  logic [15:0]              di,
    input  logic [3:0]               maskwe,
    input  logic                     we,
    input  logic                     cs,
    output logic [15:0]              dout
);

    localparam int DEPTH = 1 << `SRAM_ROW_AW;

    // Storage, undefined until written
    logic [15:0] mem [DEPTH];

    // Power pins of the hard macro
    logic stdby;
    logic sleep;
    logic pwroff_n;
    logic active;

    // Low power modes unused in this system
    assign stdby    = 1'b0;
    assign sleep    = 1'b0;
    assign pwroff_n = 1'b1;

    // Macro only responds when selected and fully powered
    assign active = cs & ~stdby & ~sleep & pwroff_n;

    // Write one nibble per mask bit
    always_ff @(posedge clk) begin
        if (active && we) begin
            for (int n = 0; n < 4; n++) begin
                if (maskwe[n]) begin
                    mem[ad][n*4 +: 4] <= di[n*4 +: 4];
                end
            end
        end
    end

    // Read returns old contents on a write cycle
    // Output holds while deselected
    always_ff @(posedge clk) begin
        if (sleep) begin
            // Sleep pulls the outputs low
            dout <= '0;
        end else if (active) begin
            dout <= mem[ad];
        end
    end

endmodule

`default_nettype wire

/* sram_bank_array.sv */
// ##############################
// Four 16K x 16 macros as a 2 x 2 grid, 32K x 32 in total
// Acts on the edge that ends each request cycle
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module sram_bank_array
    import sram_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    sram_req_if.slave  req
);

    // Each macro holds one 16-bit half of the word
    localparam int HALVES = `SRAM_DWIDTH / 16;

    // Selected bank row of the current request
    logic bank;
    // Bank row that was last read
    logic rmux;
    // Registered output of each bank row
    logic [`SRAM_BANKS-1:0][`SRAM_DWIDTH-1:0] bank_rdata;
    logic wr;

    // Upper word-address bit picks the row
    assign bank = req.addr.fields.bank;
    assign wr   = (req.kind == REQ_WRITE);

    for (genvar b = 0; b < `SRAM_BANKS; b++) begin : g_bank
        for (genvar h = 0; h < HALVES; h++) begin : g_half
            logic       cs;
            logic       we;
            logic [3:0] maskwe;

            // Only the addressed row sees the request
            assign cs = req.en & (bank == 1'(b));
            assign we = cs & wr;

            // Each byte select covers two nibbles of this half
            assign maskwe = {{2{req.wmask[h*2+1]}}, {2{req.wmask[h*2]}}};

            spram_16k16 u_mem (
                .clk    (clk),
                .ad     (req.addr.fields.row),
                .di     (req.wdata[h*16 +: 16]),
                .maskwe (maskwe),
                .we     (we),
                .cs     (cs),
                .dout   (bank_rdata[b][h*16 +: 16])
            );
        end
    end

    // Remember the row so the mux follows the macro output
    // Deselected rows keep stale data
    always_ff @(posedge clk) begin
        if (rst) begin
            rmux <= 1'b0;
        end else if (req.en) begin
            rmux <= bank;
        end
    end

    assign req.rdata = bank_rdata[rmux];

endmodule

`default_nettype wire

/* sram_consts.svh */
// ##############################
// Geometry and bus widths of the 128 KB memory subsystem
// Include wherever a width or a bank count is needed
// ##############################

`ifndef SRAM_CONSTS_SVH
`define SRAM_CONSTS_SVH

// Wishbone byte address width
`define SRAM_AWIDTH 32

// Wishbone data width
`define SRAM_DWIDTH 32

// One select per data byte
`define SRAM_SELW 4

// Word address of one 16K x 16 macro
`define SRAM_ROW_AW 14

// Bank rows in the 2 x 2 grid, picked by the upper word-address bit
`define SRAM_BANKS 2

`endif

/* sram_pkg.sv */
// ##############################
// Shared request types for the memory subsystem
// ##############################

`default_nettype none

package sram_pkg;

`include "sram_consts.svh"

    // Access direction of one request
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_e;

    // Byte address split for the 2 x 2 grid
    // Top part aliases every 128 KB
    typedef struct packed {
        logic [14:0]              high;
        logic                     bank;
        logic [`SRAM_ROW_AW-1:0]  row;
        // Byte lanes come from sel instead
        logic [1:0]               byte_off;
    } mem_addr_fields_t;

    // Same word, flat as stored or split as decoded
    typedef union packed {
        logic [`SRAM_AWIDTH-1:0]  byte_addr;
        mem_addr_fields_t         fields;
    } mem_addr_u;

endpackage

`default_nettype wire

/* sram_req_if.sv */
// ##############################
// One registered memory request, front end to bank array
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

interface sram_req_if
    import sram_pkg::*;
();

    // High for one cycle per access
    logic                     en;
    req_kind_e                kind;
    mem_addr_u                addr;
    logic [`SRAM_DWIDTH-1:0]  wdata;
    // Byte write mask, copy of sel
    logic [`SRAM_SELW-1:0]    wmask;
    // Valid the cycle after en
    logic [`SRAM_DWIDTH-1:0]  rdata;

    // Front end side
    modport master (output en, kind, addr, wdata, wmask, input rdata);

    // Bank array side
    modport slave (input en, kind, addr, wdata, wmask, output rdata);

endinterface

`default_nettype wire

/* tb_wb_sram.sv */
// ##############################
// Testbench for the Wishbone memory top level
// Reference model with data and latency checks
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module tb_wb_sram
    import sram_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    // Accesses per test
    localparam int N_BASIC   = 8;
    localparam int N_PARTIAL = 16;
    localparam int N_BANK    = 14;
    localparam int N_B2B     = 4;
    localparam int N_RANDOM  = 400;
    localparam int N_ACCESSES = N_BASIC + N_PARTIAL + N_BANK + N_B2B + N_RANDOM;
    localparam int CYCLE_LIMIT = 20 * N_ACCESSES + RESET_CYCLES;
    // Give up waiting for one ack after this many cycles
    localparam int MAX_WAIT = 16;

    logic                     clk;
    logic                     rst;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`SRAM_AWIDTH-1:0]  adr;
    logic [`SRAM_DWIDTH-1:0]  dat_w;
    logic [`SRAM_SELW-1:0]    sel;
    logic [`SRAM_DWIDTH-1:0]  dat_r;
    logic                     ack;

    // Reference memory keyed by word index
    logic [`SRAM_DWIDTH-1:0]  ref_mem [int unsigned];
    // Issued accesses waiting for their ack
    req_kind_e                pend_kind [$];
    logic [`SRAM_AWIDTH-1:0]  pend_addr [$];
    logic [`SRAM_DWIDTH-1:0]  pend_data [$];
    int unsigned              cycle_count = 0;

    always #4 clk = ~clk;

    wb_sram_top DUT (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack)
    );

    bind wb_sram_front tb_wb_sram_chk u_chk (
        .clk (clk),
        .rst (rst),
        .cyc (cyc),
        .stb (stb),
        .ack (ack),
        .en  (req.en)
    );

    // Word index from bits 16:2 so higher bits and byte offset alias
    function automatic int unsigned word_index(input logic [`SRAM_AWIDTH-1:0] a);
        return int'(a[16:2]);
    endfunction

    // New word after a write with one byte per select
    function automatic logic [`SRAM_DWIDTH-1:0] merge_word(
        input logic [`SRAM_DWIDTH-1:0] old_word,
        input logic [`SRAM_DWIDTH-1:0] wdata,
        input logic [`SRAM_SELW-1:0]   sel_bits
    );
        logic [`SRAM_DWIDTH-1:0] w;
        w = old_word;
        for (int b = 0; b < `SRAM_SELW; b++) begin
            if (sel_bits[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_rdata(
        input logic [`SRAM_DWIDTH-1:0] got,
        input logic [`SRAM_DWIDTH-1:0] exp,
        input logic [`SRAM_AWIDTH-1:0] a
    );
        if (got !== exp) begin
            $display("mismatch at %0t: read of %h gave %h, expected %h", $time, a, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_latency(
        input int unsigned got,
        input int unsigned exp,
        input req_kind_e   kind
    );
        if (got != exp) begin
            $display("mismatch at %0t: %s ack after %0d cycles, expected %0d",
                     $time, kind.name(), got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // Called on a rising edge and returns on the edge where ack is seen
    task automatic run_access(
        input req_kind_e               kind,
        input logic [`SRAM_AWIDTH-1:0] a,
        input logic [`SRAM_DWIDTH-1:0] d,
        input logic [`SRAM_SELW-1:0]   s
    );
        int unsigned             idx;
        int unsigned             waited;
        logic [`SRAM_DWIDTH-1:0] old_word;
        idx = word_index(a);
        if (kind == REQ_WRITE) begin
            old_word = ref_mem.exists(idx) ? ref_mem[idx] : '0;
            ref_mem[idx] = merge_word(old_word, d, s);
            pend_data.push_back('0);
        end else begin
            pend_data.push_back(ref_mem[idx]);
        end
        pend_kind.push_back(kind);
        pend_addr.push_back(a);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= (kind == REQ_WRITE);
        adr   <= a;
        dat_w <= d;
        sel   <= s;
        // Front end samples stb on this edge
        @(posedge clk);
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!ack && waited < MAX_WAIT);
        check_latency(waited, (kind == REQ_WRITE) ? 2 : 3, kind);
    endtask

    task automatic hold_idle(input int unsigned cycles, input logic keep_cyc);
        cyc <= keep_cyc;
        stb <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    // Read data compare on every ack
    always @(posedge clk) begin
        req_kind_e               kind_done;
        logic [`SRAM_AWIDTH-1:0] a_done;
        logic [`SRAM_DWIDTH-1:0] exp_done;
        if (!rst && ack) begin
            if (pend_kind.size() == 0) begin
                $display("error at %0t: ack seen with no access outstanding", $time);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end else begin
                kind_done = pend_kind.pop_front();
                a_done    = pend_addr.pop_front();
                exp_done  = pend_data.pop_front();
                if (kind_done == REQ_READ) begin
                    check_rdata(dat_r, exp_done, a_done);
                end
            end
        end
    end

    // Run limit and bound checker watch
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end else if (DUT.u_front.u_chk.fail_count != 0) begin
            $display("error at %0t: protocol assertion failed in the front end", $time);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    initial begin
        logic [`SRAM_AWIDTH-1:0] basic_addr [4];
        logic [`SRAM_AWIDTH-1:0] a;
        logic [`SRAM_DWIDTH-1:0] d;
        logic [13:0]             row;
        clk   = 1'b0;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = '0;
        void'($urandom(32'h3a18_a419));
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // No ack may appear on a quiet bus
        hold_idle(12, 1'b0);
        hold_idle(8, 1'b1);

        // First and last row of both bank rows
        basic_addr[0] = 32'h0000_0000;
        basic_addr[1] = 32'h0000_fffc;
        basic_addr[2] = 32'h0001_0000;
        basic_addr[3] = 32'h0001_fffc;
        for (int i = 0; i < 4; i++) begin
            run_access(REQ_WRITE, basic_addr[i], $urandom(), 4'hf);
        end
        for (int i = 0; i < 4; i++) begin
            run_access(REQ_READ, basic_addr[i], '0, 4'hf);
        end
        hold_idle(3, 1'b0);

        // Partial writes over known contents
        for (int i = 0; i < N_PARTIAL / 2; i++) begin
            run_access(REQ_WRITE, basic_addr[i % 4], $urandom(), 4'($urandom()));
            run_access(REQ_READ, basic_addr[i % 4], '0, 4'hf);
        end
        hold_idle(3, 1'b0);

        // Bit 16 splits banks
        for (int i = 0; i < 2; i++) begin
            row = 14'($urandom());
            a   = {15'd0, 1'b0, row, 2'b00};
            d   = $urandom();
            run_access(REQ_WRITE, a, d, 4'hf);
            run_access(REQ_WRITE, a | 32'h0001_0000, ~d, 4'hf);
            run_access(REQ_READ, a, '0, 4'hf);
            run_access(REQ_READ, a | 32'h0001_0000, '0, 4'hf);
        end
        // High bits and byte offset alias
        for (int i = 0; i < 2; i++) begin
            row = 14'($urandom());
            a   = {15'd0, 1'(i), row, 2'b00};
            run_access(REQ_WRITE, a, $urandom(), 4'hf);
            run_access(REQ_READ, a | (32'($urandom_range(32767, 1)) << 17), '0, 4'hf);
            run_access(REQ_READ, a | 32'h0000_0003, '0, 4'hf);
        end
        hold_idle(3, 1'b0);

        // Back to back read right after write to the same word
        a = 32'h0000_0100;
        run_access(REQ_WRITE, a, $urandom(), 4'hf);
        run_access(REQ_READ, a, '0, 4'hf);
        run_access(REQ_WRITE, a, $urandom(), 4'b0110);
        run_access(REQ_READ, a, '0, 4'hf);
        hold_idle(3, 1'b0);

        // Random mix over 16 words including aliased addresses
        for (int i = 0; i < N_RANDOM; i++) begin
            a = {15'($urandom()), 1'($urandom()), 11'd0, 3'($urandom()), 2'($urandom())};
            if (ref_mem.exists(word_index(a)) && $urandom_range(1) == 1) begin
                run_access(REQ_READ, a, '0, 4'hf);
            end else if (ref_mem.exists(word_index(a))) begin
                run_access(REQ_WRITE, a, $urandom(), 4'($urandom()));
            end else begin
                run_access(REQ_WRITE, a, $urandom(), 4'hf);
            end
            if ($urandom_range(7) == 0) begin
                hold_idle(1 + $urandom_range(2), 1'b0);
            end
        end

        hold_idle(10, 1'b0);
        if (pend_kind.size() != 0 || DUT.u_front.u_chk.fail_count != 0) begin
            $display("error: accesses without ack or failed assertions at end of run");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb_wb_sram_chk.sv */
// ##############################
// Wishbone protocol assertions, bound into the front end
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tb_wb_sram_chk (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic en
);

    // Failed assertions so far
    int unsigned fail_count = 0;

    // Ack lasts one cycle only
    a_ack_pulse: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    ) else begin
        fail_count++;
        $error("ack high for two consecutive cycles");
    end

    // Master still holds its request when ack rises
    a_ack_with_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack) |-> (cyc && stb)
    ) else begin
        fail_count++;
        $error("ack rose without cyc and stb");
    end

    // One request cycle per access
    a_en_pulse: assert property (
        @(posedge clk) disable iff (rst) en |=> !en
    ) else begin
        fail_count++;
        $error("request enable high for two consecutive cycles");
    end

    // Sync reset clears both pulses
    a_reset_quiet: assert property (
        @(posedge clk) rst |=> (!ack && !en)
    ) else begin
        fail_count++;
        $error("ack or request enable high during reset");
    end

endmodule

`default_nettype wire

/* wb_sram_front.sv */
// ##############################
// Wishbone classic slave front end of the memory
// Write acks after 2 cycles, read after 3
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module wb_sram_front
    import sram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`SRAM_AWIDTH-1:0]  adr,
    input  logic [`SRAM_DWIDTH-1:0]  dat_w,
    input  logic [`SRAM_SELW-1:0]    sel,
    output logic [`SRAM_DWIDTH-1:0]  dat_r,
    output logic                     ack,
    sram_req_if.master               req
);

    // FSM encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ISSUED = 2'd1;
    localparam logic [1:0] ST_RWAIT  = 2'd2;

    logic [1:0] state;
    logic       start;

    // New access only when idle and not in the ack cycle
    // Master still shows the old request while ack is high
    assign start = (state == ST_IDLE) && cyc && stb && !ack;

    // Control path
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            req.en  <= 1'b0;
            ack     <= 1'b0;
        end else begin
            // Pulses by default
            req.en <= 1'b0;
            ack    <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        req.en <= 1'b1;
                        state  <= ST_ISSUED;
                    end
                end
                ST_ISSUED: begin
                    // Array took the request on this edge
                    if (req.kind == REQ_WRITE) begin
                        ack   <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_RWAIT;
                    end
                end
                ST_RWAIT: begin
                    // Macro output now valid
                    ack   <= 1'b1;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request payload, captured once per access
    always_ff @(posedge clk) begin
        if (start) begin
            req.kind           <= we ? REQ_WRITE : REQ_READ;
            req.addr.byte_addr <= adr;
            req.wdata          <= dat_w;
            req.wmask          <= sel;
        end
    end

    // Read data goes out with the ack and holds until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            dat_r <= '0;
        end else if (state == ST_RWAIT) begin
            dat_r <= req.rdata;
        end
    end

endmodule

`default_nettype wire

/* wb_sram_top.sv */
// ##############################
// 128 KB Wishbone classic memory, top level
// Plain bus ports, front end plus bank array inside
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module wb_sram_top (
    input  logic                     clk,
    input  logic                     rst,
    // Wishbone classic slave
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`SRAM_AWIDTH-1:0]  adr,
    input  logic [`SRAM_DWIDTH-1:0]  dat_w,
    input  logic [`SRAM_SELW-1:0]    sel,
    output logic [`SRAM_DWIDTH-1:0]  dat_r,
    output logic                     ack
);

    // Registered request between the two stages
    sram_req_if u_req ();

    // Bus handshake and read return
    wb_sram_front u_front (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack),
        .req   (u_req.master)
    );

    // Macro grid
    sram_bank_array u_array (
        .clk (clk),
        .rst (rst),
        .req (u_req.slave)
    );

endmodule

`default_nettype wire
